/* files.f */
+incdir+source
source/rv_pkg.sv
source/decode_if.sv
source/instr_decoder.sv
source/reg_file.sv
source/id_ex_stage.sv
source/decode_read.sv
test/tb_clock.sv
test/decode_read_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= decode_read_tb
LINT_TOP  ?= decode_read
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TESTBENCH PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/decode_read_tb.sv */
`default_nettype none

`include "rv_consts.svh"

module decode_read_tb;

    typedef struct packed {
        logic [`XLEN-1:0] imm;
        rv_pkg::alu_op_e  alu_op;
        logic [7:0]       flags;  // jump, branch, a_sel, b_sel, reg_we, mem_we, mem_rr, csr
    } expect_t;

    logic               clk;
    logic               rst_n, stall, flush;
    logic [`XLEN-1:0]   id_instr, id_pc, wb_data;
    logic               wb_we;
    logic [`REG_AW-1:0] wb_rd, s2_rd, s3_rd;
    logic               s2_reg_we, s2_mem_rr, s3_reg_we, s3_mem_rr;
    logic               bubble, ex_valid, ex_is_jump, ex_is_branch, ex_a_sel_reg, ex_b_sel_reg;
    logic               ex_reg_we, ex_mem_we, ex_mem_rr, ex_csr_write;
    rv_pkg::alu_op_e    ex_alu_op;
    logic [2:0]         ex_funct3;
    logic [`REG_AW-1:0] ex_rd, ex_rs1, ex_rs2;
    logic [`XLEN-1:0]   ex_imm, ex_rs1_data, ex_rs2_data, ex_pc;
    logic [7:0]         ex_flags;

    logic [`XLEN-1:0]   shadow [`NUM_REGS];  // Expected register file contents
    logic [31:0]        lfsr;
    logic [31:0]        rnd;
    int                 errors;
    int                 timeouts;

    assign ex_flags = {ex_is_jump, ex_is_branch, ex_a_sel_reg, ex_b_sel_reg,
                       ex_reg_we, ex_mem_we, ex_mem_rr, ex_csr_write};

    tb_clock tb_clock_i (.clk(clk));

    decode_read decode_read_i (.*);

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic rv_pkg::alu_op_e model_alu(input logic [2:0] f3, input logic alt,
                                                  input logic is_r);
        rv_pkg::alu_op_e op;
        case (f3)
            3'd0:    op = (alt && is_r) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'd1:    op = rv_pkg::ALU_SLL;
            3'd2:    op = rv_pkg::ALU_SLT;
            3'd3:    op = rv_pkg::ALU_SLTU;
            3'd4:    op = rv_pkg::ALU_XOR;
            3'd5:    op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;  // Shifts honour bit 30
            3'd6:    op = rv_pkg::ALU_OR;
            default: op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    function automatic expect_t model_decode(input logic [31:0] instr);
        expect_t e;
        e.imm = '0;
        e.alu_op = rv_pkg::ALU_ADD;
        e.flags = 8'b0000_0000;
        case (rv_pkg::opcode_e'(instr[6:0]))
            rv_pkg::OPC_LUI: begin
                e.imm = {instr[31:12], 12'h000};
                e.alu_op = rv_pkg::ALU_COPY_B;
                e.flags = 8'b0000_1000;
            end
            rv_pkg::OPC_AUIPC: begin
                e.imm = {instr[31:12], 12'h000};
                e.flags = 8'b0000_1000;
            end
            rv_pkg::OPC_JAL: begin
                e.imm = 32'($signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0}));
                e.flags = 8'b1000_1000;
            end
            rv_pkg::OPC_JALR: begin
                e.imm = 32'($signed(instr[31:20]));
                e.flags = 8'b1010_1000;
            end
            rv_pkg::OPC_BRANCH: begin
                e.imm = 32'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));
                e.flags = 8'b1100_0000;
            end
            rv_pkg::OPC_LOAD: begin
                e.imm = 32'($signed(instr[31:20]));
                e.flags = 8'b0010_1010;
            end
            rv_pkg::OPC_STORE: begin
                e.imm = 32'($signed({instr[31:25], instr[11:7]}));
                e.flags = 8'b0010_0100;
            end
            rv_pkg::OPC_ARI_ITYPE: begin
                e.imm = 32'($signed(instr[31:20]));
                e.alu_op = model_alu(instr[14:12], instr[30], 1'b0);
                e.flags = 8'b0010_1000;
            end
            rv_pkg::OPC_ARI_RTYPE: begin
                e.alu_op = model_alu(instr[14:12], instr[30], 1'b1);
                e.flags = 8'b0011_1000;
            end
            rv_pkg::OPC_CSR: begin
                e.imm = 32'($signed(instr[31:20]));
                e.alu_op = rv_pkg::ALU_PASS_A;
                e.flags = 8'b0010_0001;
            end
            default: ;
        endcase
        return e;
    endfunction

    function automatic logic [31:0] r_type(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [2:0] f3,
                                           input logic alt);
        return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_empty_slot();
        check_equal("ex_valid", 32'(ex_valid), 32'd0);
        check_equal("ex write enables",
                    32'({ex_reg_we, ex_mem_we, ex_mem_rr, ex_csr_write}), 32'd0);
        check_equal("bubble", 32'(bubble), 32'd0);
    endtask

    task automatic wait_valid(input int limit);
        int n;
        n = 0;
        next_cycle();
        while (!ex_valid && n < limit) begin
            next_cycle();
            n++;
        end
        if (!ex_valid) begin
            timeouts++;
            $display("ERROR at %0t: ex_valid did not rise within %0d cycles", $time, limit);
        end
    endtask

    task automatic check_ex(input logic [31:0] instr, input logic [31:0] pc);
        expect_t e;
        e = model_decode(instr);
        check_equal("ex_valid", 32'(ex_valid), 32'd1);
        check_equal("ex_imm", ex_imm, e.imm);
        check_equal("ex_alu_op", 32'(ex_alu_op), 32'(e.alu_op));
        check_equal("ex flags", 32'(ex_flags), 32'(e.flags));
        check_equal("ex_funct3", 32'(ex_funct3), 32'(instr[14:12]));
        check_equal("ex_rd", 32'(ex_rd), 32'(instr[11:7]));
        check_equal("ex_rs1", 32'(ex_rs1), 32'(instr[19:15]));
        check_equal("ex_rs2", 32'(ex_rs2), 32'(instr[24:20]));
        check_equal("ex_rs1_data", ex_rs1_data, shadow[instr[19:15]]);
        check_equal("ex_rs2_data", ex_rs2_data, shadow[instr[24:20]]);
        check_equal("ex_pc", ex_pc, pc);
    endtask

    task automatic run_instr(input logic [31:0] instr, input logic [31:0] pc);
        id_instr = instr;
        id_pc = pc;
        wait_valid(4);
        check_ex(instr, pc);
    endtask

    task automatic write_reg(input logic [`REG_AW-1:0] rd, input logic [`XLEN-1:0] data);
        wb_we = 1'b1;
        wb_rd = rd;
        wb_data = data;
        if (rd != '0) begin
            shadow[rd] = data;
        end
        next_cycle();
        wb_we = 1'b0;
    endtask

    task automatic check_bubble(input logic exp);
        #1;
        check_equal("bubble", 32'(bubble), 32'(exp));
        next_cycle();
    endtask

    task automatic test_reset();
        for (int i = 0; i < 8; i++) begin
            next_cycle();
            check_empty_slot();
        end
        rst_n = 1'b1;
        check_empty_slot();
    endtask

    task automatic decode_one(input logic [6:0] opc);
        logic [31:0] instr;
        rnd = rand_bits(25);
        instr = {rnd[24:0], opc};
        run_instr(instr, rand_bits(32));
    endtask

    task automatic test_decode();
        decode_one(rv_pkg::OPC_LUI);
        decode_one(rv_pkg::OPC_AUIPC);
        decode_one(rv_pkg::OPC_JAL);
        decode_one(rv_pkg::OPC_JALR);
        decode_one(rv_pkg::OPC_BRANCH);
        decode_one(rv_pkg::OPC_LOAD);
        decode_one(rv_pkg::OPC_STORE);
        decode_one(rv_pkg::OPC_ARI_ITYPE);
        decode_one(rv_pkg::OPC_ARI_RTYPE);
        decode_one(rv_pkg::OPC_CSR);
        decode_one(7'b1111111);  // Not an RV32I opcode
        check_equal("ex flags", 32'(ex_flags), 32'd0);
    endtask

    task automatic test_reg_read();
        write_reg(5'd7, 32'hdead_beef);
        write_reg(5'd12, 32'h0bad_f00d);
        write_reg(5'd0, 32'hffff_ffff);
        run_instr(r_type(5'd1, 5'd7, 5'd12, 3'b000, 1'b0), 32'h0000_0100);
        // x0 read while the write-back port targets x0
        wb_we = 1'b1;
        wb_rd = 5'd0;
        wb_data = 32'hffff_ffff;
        run_instr(r_type(5'd2, 5'd0, 5'd7, 3'b111, 1'b0), 32'h0000_0104);
        wb_we = 1'b0;
        // Write-back and read of x12 in the same cycle
        wb_we = 1'b1;
        wb_rd = 5'd12;
        wb_data = 32'h1234_5678;
        shadow[12] = 32'h1234_5678;
        run_instr(r_type(5'd3, 5'd12, 5'd12, 3'b100, 1'b0), 32'h0000_0108);
        wb_we = 1'b0;
    endtask

    task automatic test_hazard();
        id_instr = r_type(5'd1, 5'd3, 5'd4, 3'b000, 1'b0);
        s2_mem_rr = 1'b1;
        s2_reg_we = 1'b1;
        s2_rd = 5'd3;
        check_bubble(1'b1);
        s2_rd = 5'd9;
        check_bubble(1'b0);
        s2_rd = 5'd4;
        s2_mem_rr = 1'b0;  // ALU result rather than a load
        check_bubble(1'b0);
        s2_mem_rr = 1'b1;
        flush = 1'b1;
        check_bubble(1'b0);
        flush = 1'b0;
        s2_mem_rr = 1'b0;
        s2_reg_we = 1'b0;
        s3_mem_rr = 1'b1;
        s3_reg_we = 1'b1;
        s3_rd = 5'd4;
        check_bubble(1'b1);
        id_instr = r_type(5'd1, 5'd0, 5'd5, 3'b000, 1'b0);
        s3_rd = 5'd0;
        check_bubble(1'b0);
        // sw x6, 0(x2) with x6 still loading
        id_instr = {7'b0000000, 5'd6, 5'd2, 3'b010, 5'd0, 7'b0100011};
        s3_rd = 5'd6;
        check_bubble(1'b1);
        check_equal("ex_valid", 32'(ex_valid), 32'd0);
        s3_mem_rr = 1'b0;
        s3_reg_we = 1'b0;
        id_instr = `INSTR_NOP;
    endtask

    task automatic test_stall_flush();
        logic [31:0] instr;
        instr = {12'h123, 5'd5, 3'b000, 5'd6, 7'b0010011};
        run_instr(instr, 32'h0000_0400);
        stall = 1'b1;
        id_instr = {20'hfffff, 5'd7, 7'b0110111};
        id_pc = 32'h0000_0404;
        next_cycle();
        next_cycle();
        check_ex(instr, 32'h0000_0400);
        flush = 1'b1;
        next_cycle();
        check_empty_slot();
        flush = 1'b0;
        stall = 1'b0;
        id_instr = `INSTR_NOP;
        next_cycle();
    endtask

    task automatic test_random();
        logic [`REG_AW-1:0] rd, rs1, rs2;
        logic [2:0]         f3;
        logic [11:0]        imm;
        logic               is_r;
        for (int i = 1; i < `NUM_REGS; i++) begin
            write_reg(5'(i), rand_bits(32));
        end
        for (int n = 0; n < 24; n++) begin
            rnd = rand_bits(1);
            is_r = rnd[0];
            rnd = rand_bits(5);
            rd = rnd[4:0];
            rnd = rand_bits(5);
            rs1 = rnd[4:0];
            rnd = rand_bits(5);
            rs2 = rnd[4:0];
            rnd = rand_bits(3);
            f3 = rnd[2:0];
            rnd = rand_bits(12);
            imm = rnd[11:0];
            if (is_r) begin
                run_instr(r_type(rd, rs1, rs2, f3, imm[10]), rand_bits(32));
            end else begin
                run_instr({imm, rs1, f3, rd, 7'b0010011}, rand_bits(32));
            end
        end
    endtask

    initial begin
        errors = 0;
        timeouts = 0;
        lfsr = 32'h1c46;
        rnd = '0;
        rst_n = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        id_instr = `INSTR_NOP;
        id_pc = '0;
        wb_we = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        s2_reg_we = 1'b0;
        s2_mem_rr = 1'b0;
        s2_rd = '0;
        s3_reg_we = 1'b0;
        s3_mem_rr = 1'b0;
        s3_rd = '0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        test_reset();
        test_decode();
        test_reg_read();
        test_hazard();
        test_stall_flush();
        test_random();
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Whole-run limit
    initial begin
        #(40 * 3000);
        $display("ERROR: run did not finish within 3000 clock cycles");
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts + 1);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk
);

    // 40 time unit period
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* source/decode_read.sv */
`default_nettype none

`include "rv_consts.svh"

module decode_read (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               flush,
    input  logic [`XLEN-1:0]   id_instr,
    input  logic [`XLEN-1:0]   id_pc,
    input  logic               wb_we,
    input  logic [`REG_AW-1:0] wb_rd,
    input  logic [`XLEN-1:0]   wb_data,
    input  logic               s2_reg_we,
    input  logic               s2_mem_rr,
    input  logic [`REG_AW-1:0] s2_rd,
    input  logic               s3_reg_we,
    input  logic               s3_mem_rr,
    input  logic [`REG_AW-1:0] s3_rd,
    output logic               bubble,
    output logic               ex_valid,
    output logic               ex_is_jump,
    output logic               ex_is_branch,
    output logic               ex_a_sel_reg,
    output logic               ex_b_sel_reg,
    output logic               ex_reg_we,
    output logic               ex_mem_we,
    output logic               ex_mem_rr,
    output logic               ex_csr_write,
    output rv_pkg::alu_op_e    ex_alu_op,
    output logic [2:0]         ex_funct3,
    output logic [`REG_AW-1:0] ex_rd,
    output logic [`REG_AW-1:0] ex_rs1,
    output logic [`REG_AW-1:0] ex_rs2,
    output logic [`XLEN-1:0]   ex_imm,
    output logic [`XLEN-1:0]   ex_rs1_data,
    output logic [`XLEN-1:0]   ex_rs2_data,
    output logic [`XLEN-1:0]   ex_pc
);

    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;

    decode_if decode_if_i ();

    instr_decoder instr_decoder_i (
        .instr (id_instr),
        .dec   (decode_if_i.dec)
    );

    // Read ports addressed straight from the decoded fields
    reg_file reg_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (decode_if_i.rs1),
        .rs2      (decode_if_i.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    id_ex_stage id_ex_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .flush        (flush),
        .dec          (decode_if_i.stage),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .id_pc        (id_pc),
        .s2_reg_we    (s2_reg_we),
        .s2_mem_rr    (s2_mem_rr),
        .s2_rd        (s2_rd),
        .s3_reg_we    (s3_reg_we),
        .s3_mem_rr    (s3_mem_rr),
        .s3_rd        (s3_rd),
        .bubble       (bubble),
        .ex_valid     (ex_valid),
        .ex_is_jump   (ex_is_jump),
        .ex_is_branch (ex_is_branch),
        .ex_a_sel_reg (ex_a_sel_reg),
        .ex_b_sel_reg (ex_b_sel_reg),
        .ex_reg_we    (ex_reg_we),
        .ex_mem_we    (ex_mem_we),
        .ex_mem_rr    (ex_mem_rr),
        .ex_csr_write (ex_csr_write),
        .ex_alu_op    (ex_alu_op),
        .ex_funct3    (ex_funct3),
        .ex_rd        (ex_rd),
        .ex_rs1       (ex_rs1),
        .ex_rs2       (ex_rs2),
        .ex_imm       (ex_imm),
        .ex_rs1_data  (ex_rs1_data),
        .ex_rs2_data  (ex_rs2_data),
        .ex_pc        (ex_pc)
    );

endmodule

`default_nettype wire

/* source/id_ex_stage.sv */
`default_nettype none

`include "rv_consts.svh"

module id_ex_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               flush,
    decode_if.stage            dec,
    input  logic [`XLEN-1:0]   rs1_data,
    input  logic [`XLEN-1:0]   rs2_data,
    input  logic [`XLEN-1:0]   id_pc,
    input  logic               s2_reg_we,
    input  logic               s2_mem_rr,
    input  logic [`REG_AW-1:0] s2_rd,
    input  logic               s3_reg_we,
    input  logic               s3_mem_rr,
    input  logic [`REG_AW-1:0] s3_rd,
    output logic               bubble,
    output logic               ex_valid,
    output logic               ex_is_jump,
    output logic               ex_is_branch,
    output logic               ex_a_sel_reg,
    output logic               ex_b_sel_reg,
    output logic               ex_reg_we,
    output logic               ex_mem_we,
    output logic               ex_mem_rr,
    output logic               ex_csr_write,
    output rv_pkg::alu_op_e    ex_alu_op,
    output logic [2:0]         ex_funct3,
    output logic [`REG_AW-1:0] ex_rd,
    output logic [`REG_AW-1:0] ex_rs1,
    output logic [`REG_AW-1:0] ex_rs2,
    output logic [`XLEN-1:0]   ex_imm,
    output logic [`XLEN-1:0]   ex_rs1_data,
    output logic [`XLEN-1:0]   ex_rs2_data,
    output logic [`XLEN-1:0]   ex_pc
);

    logic uses_rs1;
    logic uses_rs2;
    logic s2_bubble;
    logic s3_bubble;

    assign uses_rs1 = (dec.a_sel_reg || dec.is_branch) && dec.rs1 != '0;
    assign uses_rs2 = (dec.b_sel_reg || dec.mem_we || dec.is_branch) && dec.rs2 != '0;

    // Load result not ready yet in stage 2 or 3
    assign s2_bubble = s2_mem_rr && s2_reg_we
        && ((uses_rs1 && dec.rs1 == s2_rd) || (uses_rs2 && dec.rs2 == s2_rd));
    assign s3_bubble = s3_mem_rr && s3_reg_we
        && ((uses_rs1 && dec.rs1 == s3_rd) || (uses_rs2 && dec.rs2 == s3_rd));
    assign bubble = !flush && (s2_bubble || s3_bubble);

    always_ff @(posedge clk) begin
        if (!rst_n || flush || (!stall && bubble)) begin
            ex_valid     <= 1'b0;
            ex_is_jump   <= 1'b0;
            ex_is_branch <= 1'b0;
            ex_reg_we    <= 1'b0;
            ex_mem_we    <= 1'b0;
            ex_mem_rr    <= 1'b0;
            ex_csr_write <= 1'b0;
        end else if (!stall) begin
            ex_valid     <= 1'b1;
            ex_is_jump   <= dec.is_jump;
            ex_is_branch <= dec.is_branch;
            ex_reg_we    <= dec.reg_we;
            ex_mem_we    <= dec.mem_we;
            ex_mem_rr    <= dec.mem_rr;
            ex_csr_write <= dec.csr_write;
        end
    end

    // Operands and fields for execute
    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_a_sel_reg <= dec.a_sel_reg;
            ex_b_sel_reg <= dec.b_sel_reg;
            ex_alu_op    <= dec.alu_op;
            ex_funct3    <= dec.funct3;
            ex_rd        <= dec.rd;
            ex_rs1       <= dec.rs1;
            ex_rs2       <= dec.rs2;
            ex_imm       <= dec.imm;
            ex_rs1_data  <= rs1_data;
            ex_rs2_data  <= rs2_data;
            ex_pc        <= id_pc;
        end
    end

    a_store_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
        !(ex_mem_we && ex_reg_we))
        else $error("store also writes a register");

endmodule

`default_nettype wire

/* source/reg_file.sv */
`default_nettype none

`include "rv_consts.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`REG_AW-1:0] rs1,
    input  logic [`REG_AW-1:0] rs2,
    output logic [`XLEN-1:0]   rs1_data,
    output logic [`XLEN-1:0]   rs2_data,
    input  logic               wb_we,
    input  logic [`REG_AW-1:0] wb_rd,
    input  logic [`XLEN-1:0]   wb_data
);

    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];  // No storage behind x0

    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_AW-1:0] addr);
        logic [`XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wb_we && wb_rd == addr) begin
            data = wb_data;  // Write-first bypass
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_comb rs1_data = read_port(rs1);
    always_comb rs2_data = read_port(rs2);

endmodule

`default_nettype wire

/* source/instr_decoder.sv */
`default_nettype none

`include "rv_consts.svh"

module instr_decoder (
    input  logic [`XLEN-1:0] instr,
    decode_if.dec            dec
);

    rv_pkg::opcode_e  opcode;
    logic             alt_op;  // funct7 bit 5
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    // alt selects SUB over ADD and SRA over SRL
    function automatic rv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        rv_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  op = rv_pkg::ALU_SLL;
            3'b010:  op = rv_pkg::ALU_SLT;
            3'b011:  op = rv_pkg::ALU_SLTU;
            3'b100:  op = rv_pkg::ALU_XOR;
            3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  op = rv_pkg::ALU_OR;
            default: op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = rv_pkg::opcode_e'(instr[6:0]);
    assign alt_op = instr[30];

    assign dec.rd     = instr[11:7];
    assign dec.funct3 = instr[14:12];
    assign dec.rs1    = instr[19:15];
    assign dec.rs2    = instr[24:20];  // Also the shift amount for immediate shifts

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec.imm       = '0;
        dec.alu_op    = rv_pkg::ALU_ADD;
        dec.is_jump   = 1'b0;
        dec.is_branch = 1'b0;
        dec.a_sel_reg = 1'b0;
        dec.b_sel_reg = 1'b0;
        dec.reg_we    = 1'b0;
        dec.mem_we    = 1'b0;
        dec.mem_rr    = 1'b0;
        dec.csr_write = 1'b0;
        case (opcode)
            rv_pkg::OPC_LUI: begin
                dec.imm    = imm_u;
                dec.alu_op = rv_pkg::ALU_COPY_B;
                dec.reg_we = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                dec.imm    = imm_u;  // PC + imm
                dec.reg_we = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                dec.imm     = imm_j;
                dec.is_jump = 1'b1;
                dec.reg_we  = 1'b1;
            end
            rv_pkg::OPC_JALR: begin
                dec.imm       = imm_i;
                dec.is_jump   = 1'b1;
                dec.a_sel_reg = 1'b1;
                dec.reg_we    = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                dec.imm       = imm_b;  // PC relative target
                dec.is_jump   = 1'b1;
                dec.is_branch = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin
                dec.imm       = imm_i;
                dec.a_sel_reg = 1'b1;
                dec.reg_we    = 1'b1;
                dec.mem_rr    = 1'b1;
            end
            rv_pkg::OPC_STORE: begin
                dec.imm       = imm_s;
                dec.a_sel_reg = 1'b1;
                dec.mem_we    = 1'b1;
            end
            rv_pkg::OPC_ARI_ITYPE: begin
                dec.imm       = imm_i;
                dec.alu_op    = arith_op(instr[14:12], alt_op && instr[14:12] == 3'b101);
                dec.a_sel_reg = 1'b1;
                dec.reg_we    = 1'b1;
            end
            rv_pkg::OPC_ARI_RTYPE: begin
                dec.alu_op    = arith_op(instr[14:12], alt_op);
                dec.a_sel_reg = 1'b1;
                dec.b_sel_reg = 1'b1;
                dec.reg_we    = 1'b1;
            end
            rv_pkg::OPC_CSR: begin
                dec.imm       = imm_i;  // CSR address
                dec.alu_op    = rv_pkg::ALU_PASS_A;
                dec.a_sel_reg = 1'b1;
                dec.csr_write = 1'b1;
            end
            default: ;  // Unknown opcode acts as a no-op
        endcase
    end

endmodule

`default_nettype wire

/* source/decode_if.sv */
`default_nettype none

`include "rv_consts.svh"

interface decode_if;

    rv_pkg::alu_op_e     alu_op;
    logic [2:0]          funct3;
    logic [`REG_AW-1:0]  rd;
    logic [`REG_AW-1:0]  rs1;
    logic [`REG_AW-1:0]  rs2;
    logic [`XLEN-1:0]    imm;
    logic                is_jump;    // JAL, JALR and branches
    logic                is_branch;
    logic                a_sel_reg;  // Operand A from rs1, else PC
    logic                b_sel_reg;  // Operand B from rs2, else imm
    logic                reg_we;
    logic                mem_we;     // Store
    logic                mem_rr;     // Load
    logic                csr_write;

    modport dec (
        output alu_op, funct3, rd, rs1, rs2, imm,
        output is_jump, is_branch, a_sel_reg, b_sel_reg,
        output reg_we, mem_we, mem_rr, csr_write
    );

    modport stage (
        input alu_op, funct3, rd, rs1, rs2, imm,
        input is_jump, is_branch, a_sel_reg, b_sel_reg,
        input reg_we, mem_we, mem_rr, csr_write
    );

endinterface

`default_nettype wire

/* source/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // RV32I major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_ARI_ITYPE = 7'b0010011,
        OPC_ARI_RTYPE = 7'b0110011,
        OPC_CSR       = 7'b1110011
    } opcode_e;

    // Operations understood by the execute stage ALU
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_COPY_B = 4'd10,  // Result is operand B, used by LUI
        ALU_PASS_A = 4'd11   // Result is operand A, CSR write data
    } alu_op_e;

endpackage

`default_nettype wire

/* source/rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data and instruction width
`define XLEN 32

// Register address width
`define REG_AW 5

// Architectural integer registers, x0 included
`define NUM_REGS 32

// addi x0, x0, 0
`define INSTR_NOP 32'h0000_0013

`endif
